// File: mipsPkg.sv
`default_nettype none

package mipsPkg;

	// ========================================
	// widths
	// ========================================
	// machine word
	localparam int dataWidth = 32;
	// register index
	localparam int regAddrWidth = 5;

	// ========================================
	// instruction encodings
	// ========================================
	// primary opcode in instr[31:26]
	typedef enum logic [5:0] {
		opSpecial = 6'b000000,
		opJ       = 6'b000010,
		opBeq     = 6'b000100,
		opBne     = 6'b000101,
		opAddiu   = 6'b001001,
		opOri     = 6'b001101,
		opLui     = 6'b001111,
		opLw      = 6'b100011,
		opSw      = 6'b101011
	} opcodeT;

	// r-type function in instr[5:0]
	typedef enum logic [5:0] {
		fnSll  = 6'b000000,
		fnSrl  = 6'b000010,
		fnAddu = 6'b100001,
		fnSubu = 6'b100011,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnXor  = 6'b100110,
		fnSlt  = 6'b101010
	} functT;

	// ========================================
	// pipeline controls
	// ========================================
	// alu operation carried from decode into execute
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluLui
	} aluOpT;

	// operand source picked by the hazard unit
	typedef enum logic [1:0] {
		fwdNone,
		fwdFromMem,
		fwdFromWb
	} fwdSelT;

endpackage

`default_nettype wire

// File: regFile.sv
`default_nettype none
`timescale 1ns/1ps

module regFile #(
	parameter int width     = 32,
	parameter int addrWidth = 5
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 we,
	input  logic [addrWidth-1:0] wAddr,
	input  logic [width-1:0]     wData,
	input  logic [addrWidth-1:0] rAddrA,
	input  logic [addrWidth-1:0] rAddrB,
	output logic [width-1:0]     rDataA,
	output logic [width-1:0]     rDataB
);

	logic [width-1:0] regs [2**addrWidth];

	// all registers start at zero, r0 is never written
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regs <= '{default: '0};
		end else if (we && wAddr != '0) begin
			regs[wAddr] <= wData;
		end
	end

	// r0 reads zero; a write this cycle bypasses the array
	assign rDataA = (rAddrA == '0) ? '0 :
		(we && wAddr == rAddrA) ? wData : regs[rAddrA];
	assign rDataB = (rAddrB == '0) ? '0 :
		(we && wAddr == rAddrB) ? wData : regs[rAddrB];

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none
`timescale 1ns/1ps

module alu import mipsPkg::*; (
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	input  logic [4:0]           shamt,
	input  aluOpT                op,
	output logic [dataWidth-1:0] y
);

	logic lessThan;

	// slt is signed
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr:  y = a | b;
			aluXor: y = a ^ b;
			aluSlt: y = {{(dataWidth-1){1'b0}}, lessThan};
			// shifts act on rt by the shamt field
			aluSll: y = b << shamt;
			aluSrl: y = b >> shamt;
			// immediate into the upper half
			aluLui: y = {b[15:0], {(dataWidth-16){1'b0}}};
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: controlDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module controlDecoder import mipsPkg::*; (
	input  logic [dataWidth-1:0]    instr,
	output aluOpT                   aluOp,
	output logic                    aluSrcImm,
	output logic                    regWrite,
	output logic                    memRead,
	output logic                    memWrite,
	output logic                    isBranch,
	output logic                    isBne,
	output logic                    isJump,
	output logic                    useRt,
	output logic [regAddrWidth-1:0] dest
);

	opcodeT opcode;
	functT  funct;
	logic   writes;

	assign opcode = opcodeT'(instr[31:26]);
	assign funct  = functT'(instr[5:0]);

	always_comb begin
		// defaults are a nop
		aluOp     = aluAdd;
		aluSrcImm = 1'b0;
		writes    = 1'b0;
		memRead   = 1'b0;
		memWrite  = 1'b0;
		isBranch  = 1'b0;
		isBne     = 1'b0;
		isJump    = 1'b0;
		useRt     = 1'b0;
		// i-type writes rt
		dest      = instr[20:16];
		case (opcode)
			opSpecial: begin
				// r-type writes rd, reads rs and rt
				dest   = instr[15:11];
				writes = 1'b1;
				useRt  = 1'b1;
				case (funct)
					fnSll:  aluOp = aluSll;
					fnSrl:  aluOp = aluSrl;
					fnAddu: aluOp = aluAdd;
					fnSubu: aluOp = aluSub;
					fnAnd:  aluOp = aluAnd;
					fnOr:   aluOp = aluOr;
					fnXor:  aluOp = aluXor;
					fnSlt:  aluOp = aluSlt;
					// unknown funct
					default: begin
						writes = 1'b0;
						useRt  = 1'b0;
					end
				endcase
			end
			opJ: begin
				isJump = 1'b1;
			end
			opBeq: begin
				isBranch = 1'b1;
				useRt    = 1'b1;
			end
			opBne: begin
				isBranch = 1'b1;
				isBne    = 1'b1;
				useRt    = 1'b1;
			end
			opAddiu: begin
				aluSrcImm = 1'b1;
				writes    = 1'b1;
			end
			opOri: begin
				aluOp     = aluOr;
				aluSrcImm = 1'b1;
				writes    = 1'b1;
			end
			opLui: begin
				aluOp     = aluLui;
				aluSrcImm = 1'b1;
				writes    = 1'b1;
			end
			// address is base plus offset
			opLw: begin
				aluSrcImm = 1'b1;
				writes    = 1'b1;
				memRead   = 1'b1;
			end
			// rt carries the store data
			opSw: begin
				aluSrcImm = 1'b1;
				memWrite  = 1'b1;
				useRt     = 1'b1;
			end
			default: begin
				writes = 1'b0;
			end
		endcase
	end

	// r0 targets drop out here, so no later stage forwards or retires them
	assign regWrite = writes && (dest != '0);

endmodule

`default_nettype wire

// File: fetchUnit.sv
`default_nettype none
`timescale 1ns/1ps

module fetchUnit import mipsPkg::*; #(
	parameter logic [dataWidth-1:0] resetPc = '0
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 stall,
	input  logic                 branchTaken,
	input  logic [dataWidth-1:0] branchTarget,
	input  logic [dataWidth-1:0] instr,
	output logic [dataWidth-1:0] pc,
	output logic [dataWidth-1:0] instrD,
	output logic [dataWidth-1:0] pcPlus4D
);

	logic [dataWidth-1:0] pcPlus4;
	logic [dataWidth-1:0] pcNext;

	// sequential fetch
	assign pcPlus4 = pc + dataWidth'(4);

	// a taken branch sits in decode while its delay slot is fetched here,
	// so the redirect lands right after the slot
	assign pcNext = branchTaken ? branchTarget : pcPlus4;

	// pc and f/d instruction both freeze on stall
	// all-zero word is sll r0 and acts as the bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc     <= resetPc;
			instrD <= '0;
		end else if (!stall) begin
			pc     <= pcNext;
			instrD <= instr;
		end
	end

	// pc+4 for branch and jump targets in decode
	always_ff @(posedge clk) begin
		if (!stall) begin
			pcPlus4D <= pcPlus4;
		end
	end

endmodule

`default_nettype wire

// File: decodeStage.sv
`default_nettype none
`timescale 1ns/1ps

module decodeStage import mipsPkg::*; (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    bubble,
	input  logic [dataWidth-1:0]    instrD,
	input  logic [dataWidth-1:0]    pcPlus4D,
	input  fwdSelT                  fwdBranchA,
	input  fwdSelT                  fwdBranchB,
	input  logic [dataWidth-1:0]    aluResultM,
	input  logic                    wbValid,
	input  logic [regAddrWidth-1:0] wbReg,
	input  logic [dataWidth-1:0]    wbData,
	output logic                    branchTaken,
	output logic [dataWidth-1:0]    branchTarget,
	output logic [regAddrWidth-1:0] rsD,
	output logic [regAddrWidth-1:0] rtD,
	output logic                    usesRtD,
	output logic                    isBranchD,
	output logic [regAddrWidth-1:0] rsE,
	output logic [regAddrWidth-1:0] rtE,
	output logic [regAddrWidth-1:0] destE,
	output logic                    regWriteE,
	output logic                    memReadE,
	output logic                    memWriteE,
	output aluOpT                   aluOpE,
	output logic                    aluSrcImmE,
	output logic [dataWidth-1:0]    srcAE,
	output logic [dataWidth-1:0]    srcBE,
	output logic [dataWidth-1:0]    immE,
	output logic [4:0]              shamtE
);

	aluOpT                   aluOpD;
	logic                    aluSrcImmD;
	logic                    regWriteD;
	logic                    memReadD;
	logic                    memWriteD;
	logic                    isBneD;
	logic                    isJumpD;
	logic [regAddrWidth-1:0] destD;
	logic [dataWidth-1:0]    rDataA;
	logic [dataWidth-1:0]    rDataB;
	logic [dataWidth-1:0]    branchA;
	logic [dataWidth-1:0]    branchB;
	logic [dataWidth-1:0]    immD;
	logic [dataWidth-1:0]    branchOffset;
	logic [dataWidth-1:0]    jumpTarget;

	// ========================================
	// fields and controls
	// ========================================
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];

	controlDecoder ctrl (
		.instr    (instrD),
		.aluOp    (aluOpD),
		.aluSrcImm(aluSrcImmD),
		.regWrite (regWriteD),
		.memRead  (memReadD),
		.memWrite (memWriteD),
		.isBranch (isBranchD),
		.isBne    (isBneD),
		.isJump   (isJumpD),
		.useRt    (usesRtD),
		.dest     (destD)
	);

	// writeback port feeds the write side
	// write-through covers a source retiring this very cycle
	regFile #(.width(dataWidth), .addrWidth(regAddrWidth)) regs (
		.clk   (clk),
		.arstN (arstN),
		.we    (wbValid),
		.wAddr (wbReg),
		.wData (wbData),
		.rAddrA(rsD),
		.rAddrB(rtD),
		.rDataA(rDataA),
		.rDataB(rDataB)
	);

	// ori zero-extends, everything else sign-extends
	// lui only looks at the low half so either works there
	assign immD = (opcodeT'(instrD[31:26]) == opOri) ?
		{{(dataWidth-16){1'b0}}, instrD[15:0]} :
		{{(dataWidth-16){instrD[15]}}, instrD[15:0]};

	// ========================================
	// branch resolution
	// ========================================
	// only the memory stage is forwarded here
	assign branchA = (fwdBranchA == fwdFromMem) ? aluResultM : rDataA;
	assign branchB = (fwdBranchB == fwdFromMem) ? aluResultM : rDataB;

	// word offset relative to the delay slot
	assign branchOffset = {{(dataWidth-18){instrD[15]}}, instrD[15:0], 2'b00};
	// j keeps the top nibble of the delay-slot pc
	assign jumpTarget = {pcPlus4D[dataWidth-1:28], instrD[25:0], 2'b00};

	// beq on equal, bne on not equal
	assign branchTaken = isJumpD | (isBranchD & ((branchA == branchB) ^ isBneD));
	assign branchTarget = isJumpD ? jumpTarget : pcPlus4D + branchOffset;

	// ========================================
	// d/e register
	// ========================================
	// a bubble kills all side effects of the slot
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteE <= 1'b0;
			memReadE  <= 1'b0;
			memWriteE <= 1'b0;
		end else if (bubble) begin
			regWriteE <= 1'b0;
			memReadE  <= 1'b0;
			memWriteE <= 1'b0;
		end else begin
			regWriteE <= regWriteD;
			memReadE  <= memReadD;
			memWriteE <= memWriteD;
		end
	end

	// operands and indices, harmless inside a bubble
	always_ff @(posedge clk) begin
		rsE        <= rsD;
		rtE        <= rtD;
		destE      <= destD;
		aluOpE     <= aluOpD;
		aluSrcImmE <= aluSrcImmD;
		srcAE      <= rDataA;
		srcBE      <= rDataB;
		immE       <= immD;
		shamtE     <= instrD[10:6];
	end

endmodule

`default_nettype wire

// File: executeStage.sv
`default_nettype none
`timescale 1ns/1ps

module executeStage import mipsPkg::*; (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic [regAddrWidth-1:0] destE,
	input  logic                    regWriteE,
	input  logic                    memReadE,
	input  logic                    memWriteE,
	input  aluOpT                   aluOpE,
	input  logic                    aluSrcImmE,
	input  logic [dataWidth-1:0]    srcAE,
	input  logic [dataWidth-1:0]    srcBE,
	input  logic [dataWidth-1:0]    immE,
	input  logic [4:0]              shamtE,
	input  fwdSelT                  fwdA,
	input  fwdSelT                  fwdB,
	input  logic [dataWidth-1:0]    wbData,
	output logic [dataWidth-1:0]    aluResultM,
	output logic [dataWidth-1:0]    storeDataM,
	output logic [regAddrWidth-1:0] destM,
	output logic                    regWriteM,
	output logic                    memReadM,
	output logic                    dataWe
);

	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluY;

	// operand select for one source
	// memory stage wins, hazard unit already ranked it
	function automatic logic [dataWidth-1:0] pickOperand(
		input fwdSelT               sel,
		input logic [dataWidth-1:0] regVal,
		input logic [dataWidth-1:0] memVal,
		input logic [dataWidth-1:0] wbVal
	);
		case (sel)
			fwdFromMem: return memVal;
			fwdFromWb:  return wbVal;
			default:    return regVal;
		endcase
	endfunction

	// ========================================
	// operands
	// ========================================
	assign opA = pickOperand(fwdA, srcAE, aluResultM, wbData);
	// forwarded rt is also the store data
	assign opB = pickOperand(fwdB, srcBE, aluResultM, wbData);
	// immediate forms
	assign aluB = aluSrcImmE ? immE : opB;

	alu alu (
		.a    (opA),
		.b    (aluB),
		.shamt(shamtE),
		.op   (aluOpE),
		.y    (aluY)
	);

	// ========================================
	// e/m register
	// ========================================
	// store enable leaves the core straight from here
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteM <= 1'b0;
			memReadM  <= 1'b0;
			dataWe    <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			memReadM  <= memReadE;
			dataWe    <= memWriteE;
		end
	end

	always_ff @(posedge clk) begin
		aluResultM <= aluY;
		storeDataM <= opB;
		destM      <= destE;
	end

endmodule

`default_nettype wire

// File: memWbStage.sv
`default_nettype none
`timescale 1ns/1ps

module memWbStage import mipsPkg::*; (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic [dataWidth-1:0]    aluResultM,
	input  logic [regAddrWidth-1:0] destM,
	input  logic                    regWriteM,
	input  logic                    memReadM,
	input  logic [dataWidth-1:0]    dataRdata,
	output logic                    wbValid,
	output logic [regAddrWidth-1:0] wbReg,
	output logic [dataWidth-1:0]    wbData
);

	// strobe for every retiring register write
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= regWriteM;
		end
	end

	// load word or alu result, chosen before the register
	always_ff @(posedge clk) begin
		wbReg  <= destM;
		wbData <= memReadM ? dataRdata : aluResultM;
	end

endmodule

`default_nettype wire

// File: hazardUnit.sv
`default_nettype none
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
	input  logic [regAddrWidth-1:0] rsD,
	input  logic [regAddrWidth-1:0] rtD,
	input  logic                    usesRtD,
	input  logic                    isBranchD,
	input  logic [regAddrWidth-1:0] rsE,
	input  logic [regAddrWidth-1:0] rtE,
	input  logic [regAddrWidth-1:0] destE,
	input  logic                    regWriteE,
	input  logic                    memReadE,
	input  logic [regAddrWidth-1:0] destM,
	input  logic                    regWriteM,
	input  logic                    memReadM,
	input  logic [regAddrWidth-1:0] destW,
	input  logic                    regWriteW,
	output logic                    stall,
	output logic                    bubble,
	output fwdSelT                  fwdA,
	output fwdSelT                  fwdB,
	output fwdSelT                  fwdBranchA,
	output fwdSelT                  fwdBranchB
);

	logic loadUse;
	logic branchWaitE;
	logic branchWaitM;

	// ========================================
	// execute forwarding
	// ========================================
	// regWrite is already clear for r0, so no zero check
	// a load never reaches here from memory, the stall below sees to that
	assign fwdA = (regWriteM && destM == rsE) ? fwdFromMem :
		(regWriteW && destW == rsE) ? fwdFromWb : fwdNone;
	assign fwdB = (regWriteM && destM == rtE) ? fwdFromMem :
		(regWriteW && destW == rtE) ? fwdFromWb : fwdNone;

	// ========================================
	// branch operands in decode
	// ========================================
	// only alu results can come from memory
	// writeback goes through the register file
	assign fwdBranchA = (regWriteM && !memReadM && destM == rsD) ? fwdFromMem : fwdNone;
	assign fwdBranchB = (regWriteM && !memReadM && destM == rtD) ? fwdFromMem : fwdNone;

	// ========================================
	// stalls
	// ========================================
	// load in execute feeding the next instruction
	assign loadUse = memReadE && regWriteE &&
		(destE == rsD || (usesRtD && destE == rtD));

	// branch operand still being computed
	assign branchWaitE = isBranchD && regWriteE && (destE == rsD || destE == rtD);

	// branch operand is a load word not yet back
	assign branchWaitM = isBranchD && memReadM && regWriteM &&
		(destM == rsD || destM == rtD);

	// fetch and decode hold, execute takes a bubble
	assign stall  = loadUse || branchWaitE || branchWaitM;
	assign bubble = stall;

endmodule

`default_nettype wire

// File: mipsCore.sv
`default_nettype none
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; #(
	parameter logic [dataWidth-1:0] resetPc = '0
) (
	input  logic                    clk,
	input  logic                    arstN,
	// instruction port, combinational read
	output logic [dataWidth-1:0]    instrAddr,
	input  logic [dataWidth-1:0]    instr,
	// data port, write at the rising edge
	output logic [dataWidth-1:0]    dataAddr,
	output logic [dataWidth-1:0]    dataWdata,
	output logic                    dataWe,
	input  logic [dataWidth-1:0]    dataRdata,
	// one strobe per retiring register write
	output logic                    wbValid,
	output logic [regAddrWidth-1:0] wbReg,
	output logic [dataWidth-1:0]    wbData
);

	// ========================================
	// stage to stage nets
	// ========================================
	// fetch to decode
	logic [dataWidth-1:0]    instrD;
	logic [dataWidth-1:0]    pcPlus4D;
	// decode back to fetch
	logic                    branchTaken;
	logic [dataWidth-1:0]    branchTarget;
	// decode fields seen by the hazard unit
	logic [regAddrWidth-1:0] rsD;
	logic [regAddrWidth-1:0] rtD;
	logic                    usesRtD;
	logic                    isBranchD;
	// decode to execute
	logic [regAddrWidth-1:0] rsE;
	logic [regAddrWidth-1:0] rtE;
	logic [regAddrWidth-1:0] destE;
	logic                    regWriteE;
	logic                    memReadE;
	logic                    memWriteE;
	aluOpT                   aluOpE;
	logic                    aluSrcImmE;
	logic [dataWidth-1:0]    srcAE;
	logic [dataWidth-1:0]    srcBE;
	logic [dataWidth-1:0]    immE;
	logic [4:0]              shamtE;
	// execute to memory
	// the memory-stage alu result doubles as dataAddr
	logic [regAddrWidth-1:0] destM;
	logic                    regWriteM;
	logic                    memReadM;
	// hazard controls
	logic                    stall;
	logic                    bubble;
	fwdSelT                  fwdA;
	fwdSelT                  fwdB;
	fwdSelT                  fwdBranchA;
	fwdSelT                  fwdBranchB;

	// ========================================
	// stages
	// ========================================
	// pc register, pc is the instruction address
	fetchUnit #(.resetPc(resetPc)) fetch (.*, .pc(instrAddr));

	// register read, branch resolve, d/e register
	decodeStage decode (.*, .aluResultM(dataAddr));

	// alu and e/m register
	executeStage execute (.*, .aluResultM(dataAddr), .storeDataM(dataWdata));

	// m/w register and result select
	memWbStage memWb (.*, .aluResultM(dataAddr));

	// writeback outputs are the w-stage destination and strobe
	hazardUnit hazard (.*, .destW(wbReg), .regWriteW(wbValid));

endmodule

`default_nettype wire

// File: mipsCoreTb.sv
`default_nettype none
`timescale 1ns/1ps

module mipsCoreTb import mipsPkg::*; ();

	// ========================================
	// dut and memories
	// ========================================
	logic                    clk;
	logic                    arstN;
	logic [dataWidth-1:0]    instrAddr;
	logic [dataWidth-1:0]    instr;
	logic [dataWidth-1:0]    dataAddr;
	logic [dataWidth-1:0]    dataWdata;
	logic                    dataWe;
	logic [dataWidth-1:0]    dataRdata;
	logic                    wbValid;
	logic [regAddrWidth-1:0] wbReg;
	logic [dataWidth-1:0]    wbData;

	// word-indexed memories of 1 KB each
	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] expMem [256];

	// program under test and expected writebacks in order
	logic [31:0] prog [$];
	logic [4:0]  expReg [$];
	logic [31:0] expData [$];

	logic [31:0] lfsr;
	int          gotCount;
	int          cycles;
	int          checks;
	int          errors;
	time         deadline;

	mipsCore #(.resetPc(32'h0)) dut (.*);

	// fetch outside the first 1 KB returns nops
	assign instr     = (instrAddr[31:10] == '0) ? imem[instrAddr[9:2]] : '0;
	assign dataRdata = dmem[dataAddr[9:2]];

	// store lands at the rising edge
	always @(posedge clk) begin
		if (arstN && dataWe) begin
			dmem[dataAddr[9:2]] <= dataWdata;
		end
	end

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ========================================
	// helpers
	// ========================================
	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return bits;
	endfunction

	// fill from the byte address
	function automatic logic [31:0] fillWord(input int idx);
		logic [15:0] addr;
		addr = 16'(idx * 4);
		return {addr ^ 16'hc3a5, addr};
	endfunction

	function automatic logic [31:0] rIns(input functT fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
		return {opSpecial, rs, rt, rd, sh, fn};
	endfunction

	// operand order as in assembly with rt first
	function automatic logic [31:0] iIns(input opcodeT op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jIns(input logic [25:0] idx);
		return {opJ, idx};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// ========================================
	// isa model
	// ========================================
	// plain sequential mips with one delay slot
	function automatic void isaModel();
		logic [31:0] regs [32];
		logic [31:0] mem [256];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nxt;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] addr;
		logic [31:0] res;
		logic [4:0]  dst;
		logic        wr;
		int          steps;
		mem = dmem;
		regs = '{default: '0};
		expReg.delete();
		expData.delete();
		pc = '0;
		npc = 32'd4;
		steps = 0;
		while (pc < 4 * prog.size() && steps < 2000) begin
			ins  = imem[pc[9:2]];
			a    = regs[ins[25:21]];
			b    = regs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			addr = a + simm;
			nxt  = npc + 32'd4;
			dst  = ins[20:16];
			wr   = 1'b1;
			res  = '0;
			case (ins[31:26])
				opSpecial: begin
					dst = ins[15:11];
					case (ins[5:0])
						fnSll:   res = b << ins[10:6];
						fnSrl:   res = b >> ins[10:6];
						fnAddu:  res = a + b;
						fnSubu:  res = a - b;
						fnAnd:   res = a & b;
						fnOr:    res = a | b;
						fnXor:   res = a ^ b;
						fnSlt:   res = {31'b0, ($signed(a) < $signed(b))};
						default: wr = 1'b0;
					endcase
				end
				opAddiu: res = a + simm;
				opOri:   res = a | {16'h0, ins[15:0]};
				opLui:   res = {ins[15:0], 16'h0};
				opLw:    res = mem[addr[9:2]];
				opSw: begin
					mem[addr[9:2]] = b;
					wr = 1'b0;
				end
				// targets relative to the delay slot
				opBeq: begin
					wr = 1'b0;
					if (a == b) nxt = pc + 32'd4 + (simm << 2);
				end
				opBne: begin
					wr = 1'b0;
					if (a != b) nxt = pc + 32'd4 + (simm << 2);
				end
				opJ: begin
					wr = 1'b0;
					nxt = {pc[31:28], ins[25:0], 2'b00};
				end
				default: wr = 1'b0;
			endcase
			// r0 writes never retire
			if (wr && dst != 5'd0) begin
				regs[dst] = res;
				expReg.push_back(dst);
				expData.push_back(res);
			end
			pc = npc;
			npc = nxt;
			steps++;
		end
		expMem = mem;
	endfunction

	// ========================================
	// writeback comparison
	// ========================================
	always @(negedge clk) begin
		if (!arstN) begin
			checkValue("wbValid", wbValid, 0);
			checkValue("dataWe", dataWe, 0);
		end else begin
			if (wbValid) begin
				// first instruction retires 4 cycles after it is presented
				if (gotCount == 0) checkValue("wbValid cycle", cycles, 4);
				if (gotCount < expReg.size()) begin
					checkValue("wbReg", wbReg, expReg[gotCount]);
					checkValue("wbData", wbData, expData[gotCount]);
				end else begin
					errors++;
					$display("extra writeback to register %0d after the expected list", wbReg);
				end
				gotCount++;
			end else if (gotCount == 0) begin
				checkValue("dataWe", dataWe, 0);
			end
			cycles++;
		end
	end

	// ========================================
	// programs
	// ========================================
	task automatic addNops();
		repeat (4) prog.push_back('0);
	endtask

	// every program starts with a register write
	task automatic buildAluProgram();
		prog.delete();
		prog.push_back(iIns(opLui, 5, 0, 16'h1234));
		prog.push_back(iIns(opOri, 5, 5, 16'h5678));
		prog.push_back(iIns(opAddiu, 6, 0, -3));
		prog.push_back(rIns(fnAddu, 7, 5, 6, 0));
		prog.push_back(rIns(fnSubu, 8, 7, 5, 0));
		prog.push_back(rIns(fnAnd, 9, 5, 6, 0));
		prog.push_back(rIns(fnOr, 10, 5, 6, 0));
		prog.push_back(rIns(fnXor, 11, 5, 6, 0));
		prog.push_back(rIns(fnSlt, 12, 6, 5, 0));
		prog.push_back(rIns(fnSlt, 13, 5, 6, 0));
		prog.push_back(rIns(fnSll, 14, 0, 5, 4));
		prog.push_back(rIns(fnSrl, 15, 0, 6, 28));
		// zero versus sign extension
		prog.push_back(iIns(opOri, 16, 0, 16'h8001));
		prog.push_back(iIns(opAddiu, 17, 0, 16'h8001));
		// r0 target then r0 as a source
		prog.push_back(rIns(fnAddu, 0, 5, 6, 0));
		prog.push_back(rIns(fnAddu, 18, 0, 5, 0));
		addNops();
	endtask

	// back-to-back dependencies on r1..r4 only
	task automatic buildRandomProgram(input int n);
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
		int          kind;
		prog.delete();
		for (int r = 1; r <= 4; r++) begin
			prog.push_back(iIns(opAddiu, 5'(r), 0, 16'(randomBits(16))));
		end
		for (int i = 0; i < n; i++) begin
			kind = int'(randomBits(4)) % 11;
			rd   = 5'(1 + randomBits(2));
			rs   = 5'(1 + randomBits(2));
			rt   = 5'(1 + randomBits(2));
			imm  = 16'(randomBits(16));
			case (kind)
				0: prog.push_back(rIns(fnAddu, rd, rs, rt, 0));
				1: prog.push_back(rIns(fnSubu, rd, rs, rt, 0));
				2: prog.push_back(rIns(fnAnd, rd, rs, rt, 0));
				3: prog.push_back(rIns(fnOr, rd, rs, rt, 0));
				4: prog.push_back(rIns(fnXor, rd, rs, rt, 0));
				5: prog.push_back(rIns(fnSlt, rd, rs, rt, 0));
				6: prog.push_back(rIns(fnSll, rd, 0, rt, 5'(randomBits(5))));
				7: prog.push_back(rIns(fnSrl, rd, 0, rt, 5'(randomBits(5))));
				8: prog.push_back(iIns(opAddiu, rd, rs, imm));
				9: prog.push_back(iIns(opOri, rd, rs, imm));
				default: prog.push_back(iIns(opLui, rd, 0, imm));
			endcase
		end
		addNops();
	endtask

	task automatic buildLoadStoreProgram();
		prog.delete();
		prog.push_back(iIns(opAddiu, 1, 0, 16'h0040));
		prog.push_back(iIns(opLw, 2, 1, 0));
		// load-use on both sources
		prog.push_back(rIns(fnAddu, 3, 2, 2, 0));
		prog.push_back(iIns(opSw, 3, 1, 8));
		prog.push_back(iIns(opLw, 4, 1, 8));
		prog.push_back(iIns(opAddiu, 5, 4, 1));
		prog.push_back(iIns(opLw, 6, 1, 12));
		// loaded value as store data
		prog.push_back(iIns(opSw, 6, 1, 16));
		prog.push_back(iIns(opLw, 7, 1, 16));
		prog.push_back(rIns(fnOr, 8, 7, 3, 0));
		prog.push_back(iIns(opSw, 8, 1, -4));
		prog.push_back(iIns(opLw, 9, 1, -4));
		prog.push_back(rIns(fnSubu, 10, 9, 5, 0));
		addNops();
	endtask

	// word numbers in the comments
	task automatic buildBranchProgram();
		prog.delete();
		prog.push_back(iIns(opAddiu, 1, 0, 5));
		prog.push_back(iIns(opAddiu, 2, 0, 5));
		// word 2 branches to 6 while r2 is still in execute
		prog.push_back(iIns(opBeq, 2, 1, 3));
		prog.push_back(iIns(opAddiu, 3, 0, 1));
		prog.push_back(iIns(opAddiu, 4, 0, 2));
		prog.push_back(iIns(opAddiu, 4, 0, 3));
		prog.push_back(iIns(opAddiu, 5, 1, 1));
		// word 7 bne taken to 10
		prog.push_back(iIns(opBne, 1, 5, 2));
		prog.push_back(iIns(opAddiu, 6, 0, 7));
		prog.push_back(iIns(opAddiu, 6, 0, 9));
		// word 10 beq not taken
		prog.push_back(iIns(opBeq, 1, 5, 2));
		prog.push_back(iIns(opAddiu, 7, 0, 11));
		prog.push_back(iIns(opAddiu, 8, 0, 12));
		// word 13 jumps to 16
		prog.push_back(jIns(26'd16));
		prog.push_back(iIns(opAddiu, 9, 0, 14));
		prog.push_back(iIns(opAddiu, 9, 0, 15));
		// word 16 load feeds a branch
		prog.push_back(iIns(opLw, 10, 0, 16'h0020));
		prog.push_back(iIns(opBne, 0, 10, 2));
		prog.push_back(iIns(opAddiu, 11, 10, 1));
		prog.push_back(iIns(opAddiu, 12, 0, 1));
		prog.push_back(iIns(opAddiu, 13, 0, 4));
		prog.push_back(iIns(opAddiu, 14, 0, 4));
		prog.push_back('0);
		// word 23 takes r14 from the memory stage and branches to 26
		prog.push_back(iIns(opBeq, 14, 13, 2));
		prog.push_back(iIns(opAddiu, 15, 0, 24));
		prog.push_back(iIns(opAddiu, 16, 0, 25));
		prog.push_back(iIns(opAddiu, 17, 0, 26));
		addNops();
	endtask

	// ========================================
	// run control
	// ========================================
	task automatic runProgram(input string name);
		int startErrors;
		startErrors = errors;
		@(posedge clk);
		arstN <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : '0;
			dmem[i] = fillWord(i);
		end
		isaModel();
		// budget in ns including reset and drain
		deadline = $time + (prog.size() * 4 + 40) * 8;
		repeat (8) @(posedge clk);
		gotCount = 0;
		cycles = 0;
		arstN <= 1'b1;
		while (gotCount < expReg.size()) @(posedge clk);
		// drain stores and catch stray strobes
		repeat (12) @(posedge clk);
		for (int i = 0; i < 256; i++) begin
			checkValue("dmem", dmem[i], expMem[i]);
		end
		$display("%s: %0d writebacks, %0d errors", name, expReg.size(), errors - startErrors);
	endtask

	initial begin
		arstN = 1'b0;
		lfsr = 32'h228c;
		checks = 0;
		errors = 0;
		gotCount = 0;
		cycles = 0;
		deadline = 1000;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] = '0;
		end
		buildAluProgram();
		runProgram("alu");
		buildRandomProgram(40);
		runProgram("random");
		buildLoadStoreProgram();
		runProgram("load/store");
		buildBranchProgram();
		runProgram("branch");
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog deadline moves with each program
	initial begin
		@(posedge clk);
		while ($time < deadline) @(posedge clk);
		$display("timeout: the expected writebacks did not all arrive in time");
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
mipsPkg.sv
regFile.sv
alu.sv
controlDecoder.sv
fetchUnit.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
hazardUnit.sv
mipsCore.sv
mipsCoreTb.sv
